// ==== source/fp_pkg.sv ====
package fp_pkg;

    // binary32 field layout
    localparam int word_w   = 32;
    localparam int exp_w    = 8;
    localparam int frac_w   = 23;  // stored fraction, hidden bit not included
    localparam int exp_bias = 127;

    // mantissa multiplier split into digits
    localparam int digit_w    = 12;
    localparam int num_digits = 2;  // digit_w * num_digits covers frac_w + 1

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul,
        op_itof
    } fp_op_t;

    typedef enum logic [2:0] {
        add_idle,
        add_align,
        add_sign,
        add_sum,
        add_norm
    } add_state_t;

    typedef enum logic [1:0] {
        mul_idle,
        mul_start,
        mul_wait,
        mul_norm
    } mul_state_t;

endpackage

// ==== source/int_mul_seq.sv ====
`timescale 1ns/1ps

module int_mul_seq (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [fp_pkg::frac_w:0]     a,
    input  logic [fp_pkg::frac_w:0]     b,
    output logic [2*fp_pkg::frac_w+1:0] product,
    output logic                        done
);
    import fp_pkg::*;

    logic [frac_w:0]                 a_reg;
    logic [frac_w:0]                 b_reg;
    logic [$clog2(num_digits)-1:0]   a_idx;
    logic [$clog2(num_digits)-1:0]   b_idx;
    logic [$clog2(num_digits):0]     shift_dig;  // digit position of the partial product
    logic [2*digit_w-1:0]            dig_prod;
    logic [2*frac_w+1:0]             partial;
    logic                            run;

    assign dig_prod  = a_reg[digit_w-1:0] * b_reg[digit_w-1:0];
    assign shift_dig = a_idx + b_idx;
    assign partial   = {{(2*frac_w+2-2*digit_w){1'b0}}, dig_prod} << (shift_dig * digit_w);

    always_ff @(posedge clk) begin
        if (rst) begin
            run  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                a_reg   <= a;
                b_reg   <= b;
                product <= '0;
                a_idx   <= '0;
                b_idx   <= '0;
                run     <= 1'b1;
            end else if (run) begin
                product <= product + partial;
                a_reg   <= {a_reg[digit_w-1:0], a_reg[frac_w:digit_w]};  // next a digit to the bottom
                if (a_idx == num_digits - 1) begin
                    a_idx <= '0;
                    b_reg <= {b_reg[digit_w-1:0], b_reg[frac_w:digit_w]};
                    if (b_idx == num_digits - 1) begin
                        run  <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        b_idx <= b_idx + 1'b1;
                    end
                end else begin
                    a_idx <= a_idx + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/int_to_float.sv ====
`timescale 1ns/1ps

module int_to_float (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [fp_pkg::word_w-1:0] a,
    output logic [fp_pkg::word_w-1:0] result,
    output logic                      done
);
    import fp_pkg::*;

    logic [word_w-1:0]          mag;
    logic [$clog2(word_w)-1:0]  lead;  // index of the leading one
    logic [word_w-1:0]          norm;
    logic [exp_w-1:0]           exp;

    assign mag = a[word_w-1] ? -a : a;

    always_comb begin
        lead = '0;
        for (int i = 0; i < word_w; i++) begin
            if (mag[i]) begin
                lead = i[$clog2(word_w)-1:0];
            end
        end
    end

    assign norm = mag << (word_w - 1 - lead);  // leading one to the top, low bits fall off below
    assign exp  = exp_w'(exp_bias) + exp_w'(lead);

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                result <= (a == '0) ? '0 : {a[word_w-1], exp, norm[word_w-2 -: frac_w]};
            end
        end
    end

endmodule

// ==== source/fp_add.sv ====
`timescale 1ns/1ps

module fp_add (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      subtract,
    input  logic [fp_pkg::word_w-1:0] a,
    input  logic [fp_pkg::word_w-1:0] b,
    output logic [fp_pkg::word_w-1:0] result,
    output logic                      done
);
    import fp_pkg::*;

    add_state_t                state;
    logic [word_w-1:0]         a_reg;
    logic [word_w-1:0]         b_reg;
    logic                      sign_a;
    logic                      sign_b;
    logic [exp_w-1:0]          exp_a;
    logic [exp_w-1:0]          exp_b;
    logic [frac_w:0]           man_a;
    logic [frac_w:0]           man_b;
    logic signed [frac_w+2:0]  man_x;
    logic signed [frac_w+2:0]  man_y;
    logic signed [frac_w+2:0]  sum;
    logic signed [frac_w+2:0]  neg_sum;
    logic [frac_w+1:0]         mag;  // sum magnitude, one guard bit above the hidden bit
    logic [exp_w-1:0]          res_exp;
    logic                      res_sign;

    assign sign_a = a_reg[word_w-1];
    assign sign_b = b_reg[word_w-1];
    assign exp_a  = a_reg[word_w-2 -: exp_w];
    assign exp_b  = b_reg[word_w-2 -: exp_w];
    assign man_a  = (exp_a == '0) ? '0 : {1'b1, a_reg[frac_w-1:0]};
    assign man_b  = (exp_b == '0) ? '0 : {1'b1, b_reg[frac_w-1:0]};

    assign sum     = man_x + man_y;
    assign neg_sum = -sum;

    assign result = {res_sign, res_exp, mag[frac_w-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= add_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                add_idle: begin
                    if (start) begin
                        a_reg <= a;
                        b_reg <= {b[word_w-1] ^ subtract, b[word_w-2:0]};
                        state <= add_align;
                    end
                end
                add_align: begin
                    // shift the smaller operand down to the larger exponent
                    if (exp_a >= exp_b) begin
                        man_x   <= {2'b00, man_a};
                        man_y   <= {2'b00, man_b >> (exp_a - exp_b)};
                        res_exp <= exp_a;
                    end else begin
                        man_x   <= {2'b00, man_a >> (exp_b - exp_a)};
                        man_y   <= {2'b00, man_b};
                        res_exp <= exp_b;
                    end
                    state <= add_sign;
                end
                add_sign: begin
                    if (sign_a == sign_b) begin
                        res_sign <= sign_a;
                    end else begin
                        res_sign <= 1'b0;  // set again in add_sum if the difference goes negative
                        if (sign_a) begin
                            man_x <= -man_x;
                        end else begin
                            man_y <= -man_y;
                        end
                    end
                    state <= add_sum;
                end
                add_sum: begin
                    if (sum[frac_w+2]) begin
                        res_sign <= 1'b1;
                        mag      <= neg_sum[frac_w+1:0];
                    end else begin
                        mag <= sum[frac_w+1:0];
                    end
                    state <= add_norm;
                end
                add_norm: begin
                    if (mag[frac_w+1]) begin  // carry out, one step right
                        mag     <= mag >> 1;
                        res_exp <= res_exp + 1'b1;
                        state   <= add_idle;
                        done    <= 1'b1;
                    end else if (!mag[frac_w]) begin
                        if (mag == '0) begin  // full cancellation gives +0
                            res_sign <= 1'b0;
                            res_exp  <= '0;
                            state    <= add_idle;
                            done     <= 1'b1;
                        end else begin
                            mag     <= mag << 1;  // one cycle per left shift
                            res_exp <= res_exp - 1'b1;
                        end
                    end else begin
                        state <= add_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= add_idle;
            endcase
        end
    end

endmodule

// ==== source/fp_mul.sv ====
`timescale 1ns/1ps

module fp_mul (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [fp_pkg::word_w-1:0] a,
    input  logic [fp_pkg::word_w-1:0] b,
    output logic [fp_pkg::word_w-1:0] result,
    output logic                      done
);
    import fp_pkg::*;

    mul_state_t           state;
    logic [word_w-1:0]    a_reg;
    logic [word_w-1:0]    b_reg;
    logic [exp_w-1:0]     exp_a;
    logic [exp_w-1:0]     exp_b;
    logic [frac_w:0]      man_a;
    logic [frac_w:0]      man_b;
    logic                 imul_start;
    logic                 imul_done;
    logic [2*frac_w+1:0]  product;
    logic [2*frac_w+1:0]  prod_reg;
    logic [exp_w-1:0]     res_exp;
    logic                 res_sign;

    assign exp_a = a_reg[word_w-2 -: exp_w];
    assign exp_b = b_reg[word_w-2 -: exp_w];
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a_reg[frac_w-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b_reg[frac_w-1:0]};

    assign imul_start = (state == mul_start);

    int_mul_seq u_imul (
        .clk     (clk),
        .rst     (rst),
        .start   (imul_start),
        .a       (man_a),
        .b       (man_b),
        .product (product),
        .done    (imul_done)
    );

    assign result = {res_sign, res_exp, prod_reg[2*frac_w:frac_w+1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mul_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                mul_idle: begin
                    if (start) begin
                        a_reg <= a;
                        b_reg <= b;
                        state <= mul_start;
                    end
                end
                mul_start: begin
                    res_sign <= a_reg[word_w-1] ^ b_reg[word_w-1];
                    res_exp  <= exp_a + exp_b - exp_w'(exp_bias);  // wraps on overflow
                    state    <= mul_wait;
                end
                mul_wait: begin
                    if (imul_done) begin
                        prod_reg <= product;
                        res_exp  <= res_exp + 1'b1;  // assume product in [2,4) for now
                        state    <= mul_norm;
                    end
                end
                mul_norm: begin
                    if (!prod_reg[2*frac_w+1]) begin
                        if (prod_reg == '0) begin  // zero operand
                            res_sign <= 1'b0;
                            res_exp  <= '0;
                        end else begin
                            prod_reg <= prod_reg << 1;
                            res_exp  <= res_exp - 1'b1;
                        end
                    end
                    state <= mul_idle;
                    done  <= 1'b1;
                end
                default: state <= mul_idle;
            endcase
        end
    end

endmodule

// ==== source/fp_unit.sv ====
`timescale 1ns/1ps

module fp_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  fp_pkg::fp_op_t           op,
    input  logic [fp_pkg::word_w-1:0] a,
    input  logic [fp_pkg::word_w-1:0] b,
    output logic [fp_pkg::word_w-1:0] result,
    output logic                     done,
    output logic                     busy
);
    import fp_pkg::*;

    logic                accept;
    logic                add_start;
    logic                add_subtract;
    logic                mul_start;
    logic                itof_start;
    logic                add_done;
    logic                mul_done;
    logic                itof_done;
    logic [word_w-1:0]   add_result;
    logic [word_w-1:0]   mul_result;
    logic [word_w-1:0]   itof_result;
    logic                op_done;
    logic [word_w-1:0]   op_result;
    fp_op_t              sel_op;  // operator of the operation in flight

    assign accept       = start && !busy;
    assign add_start    = accept && (op == op_add || op == op_sub);
    assign add_subtract = (op == op_sub);
    assign mul_start    = accept && (op == op_mul);
    assign itof_start   = accept && (op == op_itof);

    fp_add u_add (
        .clk      (clk),
        .rst      (rst),
        .start    (add_start),
        .subtract (add_subtract),
        .a        (a),
        .b        (b),
        .result   (add_result),
        .done     (add_done)
    );

    fp_mul u_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .a      (a),
        .b      (b),
        .result (mul_result),
        .done   (mul_done)
    );

    int_to_float u_itof (
        .clk    (clk),
        .rst    (rst),
        .start  (itof_start),
        .a      (a),
        .result (itof_result),
        .done   (itof_done)
    );

    always_comb begin
        case (sel_op)
            op_mul: begin
                op_done   = mul_done;
                op_result = mul_result;
            end
            op_itof: begin
                op_done   = itof_done;
                op_result = itof_result;
            end
            default: begin  // add and sub share the adder
                op_done   = add_done;
                op_result = add_result;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
            sel_op <= op_add;
        end else begin
            done <= busy && op_done;
            if (accept) begin
                busy   <= 1'b1;
                sel_op <= op;
            end else if (op_done) begin
                busy <= 1'b0;
            end
            if (busy && op_done) begin
                result <= op_result;  // held until the next operation finishes
            end
        end
    end

endmodule

// ==== verif/fp_unit_assertions.sv ====
`timescale 1ns/1ps

module fp_unit_assertions (
    input logic clk,
    input logic rst,
    input logic done,
    input logic busy
);

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high on two consecutive cycles");

    // done is registered, so busy has already dropped when it shows
    done_while_busy: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $past(busy))
        else $error("done rose without an operation in flight");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> (!busy && !done))
        else $error("busy or done high right after reset");

endmodule

bind fp_unit fp_unit_assertions u_assertions (
    .clk  (clk),
    .rst  (rst),
    .done (done),
    .busy (busy)
);

// ==== verif/fp_unit_tb.sv ====
`timescale 1ns/1ps

module fp_unit_tb;
    import fp_pkg::*;

    localparam int done_wait_limit = 64;  // per test
    localparam int extra_watch     = 8;   // cycles watched after done for a stray pulse

    logic              clk;
    logic              rst;
    logic              start;
    fp_op_t            op;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    logic [word_w-1:0] result;
    logic              done;
    logic              busy;

    logic [1:0]        op_q[$];
    logic [word_w-1:0] a_q[$];
    logic [word_w-1:0] b_q[$];
    logic [word_w-1:0] exp_q[$];

    int   cycle_count;
    int   cycle_limit;
    int   pass_count;
    int   fail_count;
    logic hung;

    fp_unit u_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic load_golden();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] v_op;
        logic [31:0] v_a;
        logic [31:0] v_b;
        logic [31:0] v_exp;
        fd = $fopen("verif/fp_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verif/fp_unit_golden.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // comment and blank lines do not scan as four hex words
                if (rc != 0 && $sscanf(line, "%h %h %h %h", v_op, v_a, v_b, v_exp) == 4) begin
                    op_q.push_back(v_op[1:0]);
                    a_q.push_back(v_a);
                    b_q.push_back(v_b);
                    exp_q.push_back(v_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        int     waited;
        int     pulses;
        int     latency;
        logic   ok;
        fp_op_t test_op;
        ok      = 1'b1;
        waited  = 0;
        pulses  = 0;
        latency = 0;
        test_op = fp_op_t'(op_q[idx]);
        @(negedge clk);
        start = 1'b1;
        op    = test_op;
        a     = a_q[idx];
        b     = b_q[idx];
        while (pulses == 0 && waited < done_wait_limit) begin
            @(negedge clk);
            waited++;
            if (waited == 1) begin
                if (busy !== 1'b1) begin
                    $display("mismatch at %0t: busy got %b expected 1", $time, busy);
                    ok = 1'b0;
                end
                start = 1'b1;  // second start while busy, must be ignored
                op    = op_itof;
                a     = ~a_q[idx];
                b     = ~b_q[idx];
            end else begin
                start = 1'b0;
            end
            if (done) begin
                pulses++;
                latency = waited;
                if (busy !== 1'b0) begin
                    $display("mismatch at %0t: busy got %b expected 0", $time, busy);
                    ok = 1'b0;
                end
            end
        end
        if (pulses == 0) begin
            $display("test %0d: no done within %0d cycles", idx, done_wait_limit);
            hung = 1'b1;
            ok   = 1'b0;
        end else begin
            if (result !== exp_q[idx]) begin
                $display("mismatch at %0t: result got %h expected %h", $time, result, exp_q[idx]);
                ok = 1'b0;
            end
            if (test_op == op_itof && latency != 2) begin
                $display("test %0d: done came %0d cycles after start instead of 2", idx, latency);
                ok = 1'b0;
            end
            repeat (extra_watch) begin
                @(negedge clk);
                if (done) begin
                    pulses++;
                end
            end
            if (pulses != 1) begin
                $display("test %0d: saw %0d done pulses, the start while busy was taken",
                         idx, pulses);
                ok = 1'b0;
            end
            if (busy !== 1'b0) begin
                $display("mismatch at %0t: busy got %b expected 0", $time, busy);
                ok = 1'b0;
            end
            if (result !== exp_q[idx]) begin  // result must hold after done
                $display("mismatch at %0t: result got %h expected %h", $time, result, exp_q[idx]);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s a=%h b=%h result=%h expected=%h %s", idx, test_op.name(),
                 a_q[idx], b_q[idx], result, exp_q[idx], ok ? "ok" : "FAIL");
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        op          = op_add;
        a           = '0;
        b           = '0;
        cycle_count = 0;
        cycle_limit = done_wait_limit + 20;
        pass_count  = 0;
        fail_count  = 0;
        hung        = 1'b0;
        load_golden();
        if (op_q.size() == 0) begin
            $display("error: no test vectors were read from the golden file");
            fail_count++;
        end
        cycle_limit = op_q.size() * done_wait_limit + 20;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // outputs straight out of reset
        if (busy !== 1'b0) begin
            $display("mismatch at %0t: busy got %b expected 0", $time, busy);
            fail_count++;
        end
        if (done !== 1'b0) begin
            $display("mismatch at %0t: done got %b expected 0", $time, done);
            fail_count++;
        end
        if (result !== '0) begin
            $display("mismatch at %0t: result got %h expected %h", $time, result, 32'h0);
            fail_count++;
        end
        for (int i = 0; i < op_q.size() && !hung; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d passed, %0d failed", op_q.size(), pass_count,
                 fail_count);
        if (fail_count == 0 && !hung) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verif/fp_unit_golden.txt ====
// op a b expected, all hex; op 0 add, 1 sub, 2 mul, 3 itof (b unused)
// results truncate, exponent field zero reads as zero
0 3f800000 40000000 40400000
0 3f800000 3f800001 40000000
0 bf800000 c0000000 c0400000
0 40a00000 c0000000 40400000
0 40000000 c0a00000 c0400000
0 40400000 c0400000 00000000
0 bfc00000 3fc00000 00000000
0 3fc00000 bfb00000 3e000000
0 3f800000 bf7fffff 34000000
0 00000000 40200000 40200000
1 40a00000 40000000 40400000
1 40000000 40a00000 c0400000
1 bf800000 c0000000 3f800000
1 41200000 41200000 00000000
1 3f800000 3f000000 3f000000
2 40000000 40400000 40c00000
2 3fc00000 3fc00000 40100000
2 bfc00000 c0800000 40c00000
2 00000000 40a00000 00000000
2 c0400000 00000000 00000000
2 3f800001 3f800001 3f800002
2 41200000 3f000000 40a00000
3 00000001 00000000 3f800000
3 0000000a 00000000 41200000
3 fffffffa 00000000 c0c00000
3 00000000 00000000 00000000
3 7fffffff 00000000 4effffff
3 80000000 00000000 cf000000
3 feffffff 00000000 cb800000

// ==== filelist.f ====
source/fp_pkg.sv
source/int_mul_seq.sv
source/int_to_float.sv
source/fp_add.sv
source/fp_mul.sv
source/fp_unit.sv
verif/fp_unit_assertions.sv
verif/fp_unit_tb.sv
